// ==== compile.f ====
+incdir+.
bridge_pkg.sv
ahb_capture.sv
apb_decoder.sv
apb_sequencer.sv
ahb2apb_bridge.sv
tb_clock_gen.sv
bridge_properties.sv
tb_ahb2apb.sv

// ==== Bender.yml ====
package:
  name: ahb2apb_bridge

sources:
  - include_dirs:
      - .
    files:
      - bridge_pkg.sv
      - ahb_capture.sv
      - apb_decoder.sv
      - apb_sequencer.sv
      - ahb2apb_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - bridge_properties.sv
      - tb_ahb2apb.sv

// ==== tb_ahb2apb.sv ====
// Testbench top; random AHB transfers into the bridge, four APB slave models, read-data checks
`timescale 1ns/1ps
`include "bridge_defines.svh"

module tb_ahb2apb;

  import bridge_pkg::*;

  localparam int num_mapped   = 32;
  localparam int num_unmapped = 4;
  localparam int num_ignored  = 4;
  // Worst transfer is about 8 cycles with 3 wait states
  localparam int cycle_limit  = (num_mapped + num_unmapped + num_ignored) * 10 + 8;

  localparam addr_t slave_base [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLV0_BASE, `BRIDGE_SLV1_BASE, `BRIDGE_SLV2_BASE, `BRIDGE_SLV3_BASE
  };
  localparam addr_t slave_limit [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLV0_LIMIT, `BRIDGE_SLV1_LIMIT, `BRIDGE_SLV2_LIMIT, `BRIDGE_SLV3_LIMIT
  };
  localparam data_t slave_key [`BRIDGE_NUM_SLAVES] = '{
    32'hA5A5_0000, 32'h5A5A_1111, 32'hC3C3_2222, 32'h3C3C_3333
  };

  logic        hclk7;
  logic        hreset_n7;
  logic        hsel = 1'b0;
  addr_t       haddr = '0;
  htrans_e     htrans = HTRANS_IDLE;
  logic        hwrite = 1'b0;
  data_t       hwdata = '0;
  logic        hready;
  data_t       hrdata;
  slave_sel_t  pready = '0;
  slave_data_t prdata = '0;
  slave_sel_t  psel;
  logic        penable;
  addr_t       paddr;
  logic        pwrite;
  data_t       pwdata;
  int          wait_left [`BRIDGE_NUM_SLAVES];
  int          cycle_count = 0;

  tb_clock_gen clk_gen (
    .hclk7     (hclk7),
    .hreset_n7 (hreset_n7)
  );

  ahb2apb_bridge uut (.*);

  bind ahb2apb_bridge bridge_properties u_props (.*);

  function automatic data_t expected_rdata(addr_t a);
    data_t result;
    result = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      if (a >= slave_base[i] && a <= slave_limit[i]) begin
        result = a ^ slave_key[i];
      end
    end
    return result;
  endfunction

  // ------------------------------------------------------------
  // AHB master
  // ------------------------------------------------------------
  task automatic ahb_transfer(string name, addr_t addr, logic wr, htrans_e trans,
                              data_t wdata);
    data_t exp;
    @(posedge hclk7);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= trans;
    hwrite <= wr;
    // Accept edge, data phase follows
    @(posedge hclk7);
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwdata <= wdata;
    @(negedge hclk7);
    while (!hready) @(negedge hclk7);
    if (!wr) begin
      exp = expected_rdata(addr);
      if (hrdata !== exp) begin
        $display("ERR %s read: addr %h expected %h actual %h", name, addr, exp, hrdata);
        $display("Done: errors found");
        $fatal(1, "read data mismatch");
      end
    end
  endtask

  task automatic ahb_ignored(logic sel, htrans_e trans);
    @(posedge hclk7);
    hsel   <= sel;
    htrans <= trans;
    haddr  <= `BRIDGE_SLV1_BASE;
    @(posedge hclk7);
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
  endtask

  // APB slaves, 0 to 3 wait states, read data is paddr XOR the slave key
  always @(posedge hclk7) begin
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      prdata[i] <= paddr ^ slave_key[i];
      if (psel[i] && !penable) begin
        wait_left[i] = $urandom_range(3, 0);
        pready[i]   <= (wait_left[i] == 0);
      end else if (psel[i] && penable && !pready[i]) begin
        wait_left[i] = wait_left[i] - 1;
        pready[i]   <= (wait_left[i] == 0);
      end else begin
        pready[i] <= 1'b0;
      end
    end
  end

  always @(posedge hclk7) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  // Stop at the first failed protocol assertion
  always @(negedge hclk7) begin
    if (uut.u_props.fail_count != 0) begin
      $display("A bridge protocol assertion failed, see the message above");
      $display("Done: errors found");
      $fatal(1, "assertion failure");
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    addr_t   addr;
    data_t   wdata;
    logic    wr;
    int      s;
    htrans_e trans;
    void'($urandom(54));
    wait (hreset_n7 === 1'b1);
    ahb_ignored(1'b0, HTRANS_NONSEQ);
    ahb_ignored(1'b1, HTRANS_IDLE);
    ahb_ignored(1'b1, HTRANS_BUSY);
    ahb_ignored(1'b0, HTRANS_SEQ);
    for (int n = 0; n < num_mapped + num_unmapped; n++) begin
      wdata = $urandom();
      trans = ($urandom_range(1, 0) == 1) ? HTRANS_SEQ : HTRANS_NONSEQ;
      if (n % 9 == 8) begin
        // Past the last window, alternating read and write
        wr   = (n % 2 == 1);
        addr = `BRIDGE_SLV3_LIMIT + 32'd1 + ($urandom() & 32'h00FF_FFFC);
        ahb_transfer("unmapped", addr, wr, trans, wdata);
      end else begin
        wr   = ($urandom_range(1, 0) == 1);
        s    = $urandom_range(`BRIDGE_NUM_SLAVES - 1, 0);
        addr = slave_base[s] + (($urandom() % (slave_limit[s] - slave_base[s] + 1)) & ~32'h3);
        ahb_transfer("mapped", addr, wr, trans, wdata);
      end
    end
    repeat (2) @(posedge hclk7);
    if (uut.u_props.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== bridge_properties.sv ====
// Protocol checker for the bridge; bind to ahb2apb_bridge, failures raise $error
`timescale 1ns/1ps
`include "bridge_defines.svh"

module bridge_properties (
  input logic                   hclk7,
  input logic                   hreset_n7,
  input logic                   hsel,
  input bridge_pkg::addr_t      haddr,
  input bridge_pkg::htrans_e    htrans,
  input logic                   hwrite,
  input bridge_pkg::data_t      hwdata,
  input logic                   hready,
  input bridge_pkg::slave_sel_t pready,
  input bridge_pkg::slave_sel_t psel,
  input logic                   penable,
  input bridge_pkg::addr_t      paddr,
  input logic                   pwrite,
  input bridge_pkg::data_t      pwdata
);

  import bridge_pkg::*;

  int unsigned fail_count = 0;
  logic        accept;
  logic        ready_sel;
  addr_t       acc_addr;
  logic        acc_write;
  logic        data_first;
  data_t       acc_wdata;

  assign accept    = hready && hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
  assign ready_sel = |(psel & pready);

  // One-hot select taken straight from the address map
  function automatic slave_sel_t window_of(addr_t a);
    window_of    = '0;
    window_of[0] = (a >= `BRIDGE_SLV0_BASE) && (a <= `BRIDGE_SLV0_LIMIT);
    window_of[1] = (a >= `BRIDGE_SLV1_BASE) && (a <= `BRIDGE_SLV1_LIMIT);
    window_of[2] = (a >= `BRIDGE_SLV2_BASE) && (a <= `BRIDGE_SLV2_LIMIT);
    window_of[3] = (a >= `BRIDGE_SLV3_BASE) && (a <= `BRIDGE_SLV3_LIMIT);
  endfunction

  function automatic void note_failure(string what);
    fail_count++;
    $error("%s", what);
  endfunction

  // Last accepted AHB address phase
  always @(posedge hclk7) begin
    data_first <= accept;
    if (accept) begin
      acc_addr  <= haddr;
      acc_write <= hwrite;
    end
    // Write data as driven in the first data-phase cycle
    if (data_first) begin
      acc_wdata <= hwdata;
    end
  end

  // ------------------------------------------------------------
  // Reset and APB sequence
  // ------------------------------------------------------------
  reset_idle: assert property (@(posedge hclk7)
    (!hreset_n7 || $rose(hreset_n7)) |-> hready && psel == '0 && !penable)
    else note_failure("bridge not idle during or after reset");

  mapped_start: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (accept && window_of(haddr) != '0) |=>
      psel == '0 ##1 psel == window_of(acc_addr) && !penable)
    else note_failure("mapped transfer did not start its setup phase after acceptance");

  setup_decode: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (psel != '0 && !penable) |->
      psel == window_of(acc_addr) && paddr == acc_addr && pwrite == acc_write)
    else note_failure("setup phase select, address or direction wrong");

  access_hold: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (psel != '0 && !(penable && ready_sel)) |=>
      penable && $stable(psel) && $stable(paddr) && $stable(pwrite))
    else note_failure("access phase missing or APB signals changed early");

  access_end: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (penable && ready_sel) |=> !penable && psel == '0)
    else note_failure("penable or psel still high after completion");

  write_data: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (penable && pwrite) |-> pwdata == acc_wdata)
    else note_failure("pwdata differs from the data-phase hwdata during a write");

  // ------------------------------------------------------------
  // AHB side
  // ------------------------------------------------------------
  wait_hready: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (penable && !ready_sel) |-> !hready)
    else note_failure("hready high while the slave inserts wait states");

  unmapped_done: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (accept && window_of(haddr) == '0) |=> !hready && psel == '0 ##1 hready && psel == '0)
    else note_failure("unmapped transfer did not complete two cycles after acceptance");

  ignored_idle: assert property (@(posedge hclk7) disable iff (!hreset_n7)
    (hready && !accept) |=> hready && psel == '0)
    else note_failure("bridge reacted to an ignored transfer");

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and power-on reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
  output logic hclk7,
  output logic hreset_n7
);

  localparam int half_period  = 20;
  localparam int reset_cycles = 8;

  // Reset falls just after time zero so every flop sees a clean edge
  initial begin
    hclk7     = 1'b0;
    hreset_n7 = 1'b1;
    #1;
    hreset_n7 = 1'b0;
    repeat (reset_cycles) @(posedge hclk7);
    hreset_n7 <= 1'b1;
  end

  always #(half_period) hclk7 = ~hclk7;

endmodule

// ==== ahb2apb_bridge.sv ====
// AHB to APB bridge top; connect an AHB master port on one side and four APB slaves on the other
`timescale 1ns/1ps

module ahb2apb_bridge (
  input  logic                    hclk7,
  input  logic                    hreset_n7,
  // AHB side
  input  logic                    hsel,
  input  bridge_pkg::addr_t       haddr,
  input  bridge_pkg::htrans_e     htrans,
  input  logic                    hwrite,
  input  bridge_pkg::data_t       hwdata,
  output logic                    hready,
  output bridge_pkg::data_t       hrdata,
  // APB side
  input  bridge_pkg::slave_sel_t  pready,
  input  bridge_pkg::slave_data_t prdata,
  output bridge_pkg::slave_sel_t  psel,
  output logic                    penable,
  output bridge_pkg::addr_t       paddr,
  output logic                    pwrite,
  output bridge_pkg::data_t       pwdata
);

  import bridge_pkg::*;

  // Capture to sequencer
  logic       xfer_valid;
  addr_t      xfer_addr;
  logic       xfer_write;
  logic       xfer_done;
  data_t      xfer_rdata;

  // Decoder to sequencer
  slave_sel_t slave_sel;
  logic       slave_hit;

  // Write data needs no staging, hwdata is stable through the data phase
  assign pwdata = hwdata;

  ahb_capture u_capture (
    .hclk7      (hclk7),
    .hreset_n7  (hreset_n7),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .xfer_done  (xfer_done),
    .xfer_rdata (xfer_rdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .xfer_valid (xfer_valid),
    .xfer_addr  (xfer_addr),
    .xfer_write (xfer_write)
  );

  apb_decoder u_decoder (
    .hclk7     (hclk7),
    .hreset_n7 (hreset_n7),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hready    (hready),
    .slave_sel (slave_sel),
    .slave_hit (slave_hit)
  );

  apb_sequencer u_sequencer (
    .hclk7      (hclk7),
    .hreset_n7  (hreset_n7),
    .xfer_valid (xfer_valid),
    .xfer_addr  (xfer_addr),
    .xfer_write (xfer_write),
    .slave_sel  (slave_sel),
    .slave_hit  (slave_hit),
    .pready     (pready),
    .prdata     (prdata),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .xfer_done  (xfer_done),
    .xfer_rdata (xfer_rdata)
  );

endmodule

// ==== apb_sequencer.sv ====
// APB master FSM; drives one access per captured AHB transfer and reports completion
`timescale 1ns/1ps

module apb_sequencer (
  input  logic                    hclk7,
  input  logic                    hreset_n7,
  input  logic                    xfer_valid,
  input  bridge_pkg::addr_t       xfer_addr,
  input  logic                    xfer_write,
  input  bridge_pkg::slave_sel_t  slave_sel,
  input  logic                    slave_hit,
  input  bridge_pkg::slave_sel_t  pready,
  input  bridge_pkg::slave_data_t prdata,
  output bridge_pkg::slave_sel_t  psel,
  output logic                    penable,
  output bridge_pkg::addr_t       paddr,
  output logic                    pwrite,
  output logic                    xfer_done,
  output bridge_pkg::data_t       xfer_rdata
);

  import bridge_pkg::*;

  apb_state_e state;
  logic       pready_mux;
  data_t      prdata_mux;

  // ------------------------------------------------------------
  // Selected slave response
  // ------------------------------------------------------------
  assign pready_mux = |(psel & pready);

  always_comb begin
    prdata_mux = '0;
    for (int i = 0; i < $bits(psel); i++) begin
      if (psel[i]) begin
        prdata_mux = prdata_mux | prdata[i];
      end
    end
  end

  // Completion: slave ready in ACCESS, or an unmapped address seen in IDLE
  assign xfer_done = ((state == APB_ACCESS) && pready_mux) ||
                     ((state == APB_IDLE) && xfer_valid && !slave_hit);

  // psel is clear for unmapped addresses so this reads zero
  assign xfer_rdata = xfer_done ? prdata_mux : '0;

  // ------------------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // ------------------------------------------------------------
  always_ff @(posedge hclk7 or negedge hreset_n7) begin
    if (!hreset_n7) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (xfer_valid && slave_hit) begin
            state  <= APB_SETUP;
            psel   <= slave_sel;
            paddr  <= xfer_addr;
            pwrite <= xfer_write;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end

        APB_ACCESS: begin
          // Stay here while the slave inserts wait states
          if (pready_mux) begin
            state   <= APB_IDLE;
            penable <= 1'b0;
            psel    <= '0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          penable <= 1'b0;
          psel    <= '0;
        end
      endcase
    end
  end

endmodule

// ==== apb_decoder.sv ====
// APB address decoder; registers a one-hot slave select for each accepted AHB transfer
`timescale 1ns/1ps
`include "bridge_defines.svh"

module apb_decoder (
  input  logic                   hclk7,
  input  logic                   hreset_n7,
  input  logic                   hsel,
  input  bridge_pkg::addr_t      haddr,
  input  bridge_pkg::htrans_e    htrans,
  input  logic                   hready,
  output bridge_pkg::slave_sel_t slave_sel,
  output logic                   slave_hit
);

  import bridge_pkg::*;

  // Window table, one entry per slave
  localparam addr_t win_base [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLV0_BASE, `BRIDGE_SLV1_BASE, `BRIDGE_SLV2_BASE, `BRIDGE_SLV3_BASE
  };
  localparam addr_t win_limit [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLV0_LIMIT, `BRIDGE_SLV1_LIMIT, `BRIDGE_SLV2_LIMIT, `BRIDGE_SLV3_LIMIT
  };

  logic       accept;
  slave_sel_t match;

  assign accept = hready && hsel &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  always_comb begin
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      match[i] = (haddr >= win_base[i]) && (haddr <= win_limit[i]);
    end
  end

  // Result holds until the next accepted transfer
  always_ff @(posedge hclk7 or negedge hreset_n7) begin
    if (!hreset_n7) begin
      slave_sel <= '0;
      slave_hit <= 1'b0;
    end else if (accept) begin
      slave_sel <= match;
      slave_hit <= |match;
    end
  end

endmodule

// ==== ahb_capture.sv ====
// AHB slave front end; accepts one transfer, holds it during the data phase, returns read data
`timescale 1ns/1ps

module ahb_capture (
  input  logic                hclk7,
  input  logic                hreset_n7,
  input  logic                hsel,
  input  bridge_pkg::addr_t   haddr,
  input  bridge_pkg::htrans_e htrans,
  input  logic                hwrite,
  input  logic                xfer_done,
  input  bridge_pkg::data_t   xfer_rdata,
  output logic                hready,
  output bridge_pkg::data_t   hrdata,
  output logic                xfer_valid,
  output bridge_pkg::addr_t   xfer_addr,
  output logic                xfer_write
);

  import bridge_pkg::*;

  logic data_phase;
  logic accept;

  // Only NONSEQ and SEQ carry a transfer
  assign accept = hready && hsel &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Wait states last for the whole data phase
  assign hready     = ~data_phase;
  assign xfer_valid = data_phase;

  // ------------------------------------------------------------
  // Address phase / data phase tracking
  // ------------------------------------------------------------
  always_ff @(posedge hclk7 or negedge hreset_n7) begin
    if (!hreset_n7) begin
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else if (!data_phase) begin
      if (accept) begin
        data_phase <= 1'b1;
      end
    end else if (xfer_done) begin
      // Sequencer finished, back to address phase
      data_phase <= 1'b0;
      hrdata     <= xfer_rdata;
    end
  end

  // Address and direction of the accepted transfer
  always_ff @(posedge hclk7 or negedge hreset_n7) begin
    if (!hreset_n7) begin
      xfer_addr  <= '0;
      xfer_write <= 1'b0;
    end else if (accept) begin
      xfer_addr  <= haddr;
      xfer_write <= hwrite;
    end
  end

endmodule

// ==== bridge_pkg.sv ====
// Shared bridge types; import into any module that uses bus words, selects or FSM states
`include "bridge_defines.svh"

package bridge_pkg;

  // Bus words
  typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
  typedef logic [`BRIDGE_DATA_W-1:0] data_t;

  // One bit per APB slave
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] slave_sel_t;
  typedef data_t [`BRIDGE_NUM_SLAVES-1:0] slave_data_t;

  // AHB htrans encodings
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // One-hot APB sequencer state
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_e;

endpackage

// ==== bridge_defines.svh ====
// Bus widths, slave count and APB address map; include wherever these constants are needed
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// Fixed number of APB slaves
`define BRIDGE_NUM_SLAVES 4

// ------------------------------------------------------------
// Slave address windows, 4 KB each
// ------------------------------------------------------------
`define BRIDGE_SLV0_BASE  32'h0000_0000
`define BRIDGE_SLV0_LIMIT 32'h0000_0FFF

`define BRIDGE_SLV1_BASE  32'h0000_1000
`define BRIDGE_SLV1_LIMIT 32'h0000_1FFF

`define BRIDGE_SLV2_BASE  32'h0000_2000
`define BRIDGE_SLV2_LIMIT 32'h0000_2FFF

`define BRIDGE_SLV3_BASE  32'h0000_3000
`define BRIDGE_SLV3_LIMIT 32'h0000_3FFF

`endif
